// File: project.f
axi_pkg.sv
mem_pkg.sv
sram_array.sv
axi_sram_ctrl.sv
axi_sram_top.sv
tb_clock_gen.sv
tb_axi_sram.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the AXI SRAM testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f project.f --top-module tb_axi_sram -o tb_axi_sram
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_axi_sram > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation run returned status $status"
    exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
    exit 1
fi
exit 0

// File: tb_axi_sram.sv
`timescale 1ns/1ps

module tb_axi_sram
    import axi_pkg::*;
();

    localparam logic [31:0] BASE_ADDR   = 32'h8000_0000;
    localparam int          DEPTH_WORDS = 256;
    localparam int          IDX_W       = $clog2(DEPTH_WORDS);
    localparam logic [31:0] WIN_BYTES   = 32'(DEPTH_WORDS * 4);
    localparam int          PRELOAD     = 64;      // Words known to the model
    localparam int          N_RANDOM    = 200;
    // About 300 transactions of at most 8 cycles plus margin
    localparam int          TIMEOUT_CYCLES = 300 * 8 + 1600;

    logic    clk;
    logic    rst;
    axi_ar_t ar;
    logic    ar_valid;
    logic    ar_ready;
    axi_aw_t aw;
    logic    aw_valid;
    logic    aw_ready;
    axi_w_t  w;
    logic    w_valid;
    logic    w_ready;
    axi_b_t  b;
    logic    b_valid;
    logic    b_ready;
    axi_r_t  r;
    logic    r_valid;
    logic    r_ready;

    logic [31:0] shadow [DEPTH_WORDS];
    axi_r_t      r_exp_q [$];
    axi_b_t      b_exp_q [$];
    axi_r_t      r_exp;
    axi_b_t      b_exp;
    logic [31:0] lcg_state = 32'h677d86bd;
    logic        started;
    logic        dual_test;
    int          ar_hs_count = 0;
    int          ar_hs_mark;
    int          errors = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    int          cycle_count;

    tb_clock_gen u_clk_gen (.clk(clk), .rst(rst));

    axi_sram_top #(
        .BASE_ADDR   (BASE_ADDR),
        .DEPTH_WORDS (DEPTH_WORDS)
    ) u_axi_sram_top (.*);

    always @(posedge clk) begin
        if (!rst && ar_valid && ar_ready) begin
            ar_hs_count <= ar_hs_count + 1;
        end
    end

    a_idle_after_reset: assert property (@(posedge clk) disable iff (rst)
        !started |-> !(ar_ready || aw_ready || w_ready || r_valid || b_valid))
    else begin
        $display("error: ar_ready/aw_ready/w_ready/r_valid/b_valid expected 0x00 actual 0x%02h",
                 {ar_ready, aw_ready, w_ready, r_valid, b_valid});
        errors++;
    end

    a_r_data: assert property (@(posedge clk) disable iff (rst)
        (r_valid && r_ready) |-> (r.data == r_exp.data))
    else begin
        $display("error: r.data expected 0x%08h actual 0x%08h", r_exp.data, r.data);
        errors++;
    end

    a_r_tag: assert property (@(posedge clk) disable iff (rst)
        (r_valid && r_ready) |-> (r.id == r_exp.id && r.resp == r_exp.resp && r.last))
    else begin
        $display("error: r.id/r.resp/r.last expected 0x%h/0x%h/0x1 actual 0x%h/0x%h/0x%h",
                 r_exp.id, r_exp.resp, r.id, r.resp, r.last);
        errors++;
    end

    a_b_tag: assert property (@(posedge clk) disable iff (rst)
        (b_valid && b_ready) |-> (b.id == b_exp.id && b.resp == b_exp.resp))
    else begin
        $display("error: b.id/b.resp expected 0x%h/0x%h actual 0x%h/0x%h",
                 b_exp.id, b_exp.resp, b.id, b.resp);
        errors++;
    end

    a_r_hold: assert property (@(posedge clk) disable iff (rst)
        (r_valid && !r_ready) |=> (r_valid && $stable(r)))
    else begin
        $display("error: r changed under back-pressure, r_valid 0x%h r 0x%h", r_valid, r);
        errors++;
    end

    a_b_hold: assert property (@(posedge clk) disable iff (rst)
        (b_valid && !b_ready) |=> (b_valid && $stable(b)))
    else begin
        $display("error: b changed under back-pressure, b_valid 0x%h b 0x%h", b_valid, b);
        errors++;
    end

    a_read_first: assert property (@(posedge clk) disable iff (rst)
        (dual_test && aw_valid && aw_ready) |-> (ar_hs_count != ar_hs_mark))
    else begin
        $display("write address was accepted before the pending read address");
        errors++;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic pick_ready(input logic bp);
        logic [31:0] v;
        if (!bp) begin
            return 1'b1;
        end
        v = lcg_next();
        return v[17:16] != 2'b00;   // Ready three cycles in four
    endfunction

    function automatic logic in_window(input logic [31:0] addr);
        return (addr >= BASE_ADDR) && (addr < BASE_ADDR + WIN_BYTES);
    endfunction

    function automatic logic [IDX_W-1:0] word_index(input logic [31:0] addr);
        return IDX_W'((addr - BASE_ADDR) >> 2);
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  strb);
        logic [31:0] res;
        res = old_word;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                res[i*8 +: 8] = new_word[i*8 +: 8];
            end
        end
        return res;
    endfunction

    task automatic expect_read(input logic [31:0] addr, input logic [3:0] id);
        axi_r_t exp;
        exp.id   = id;
        exp.last = 1'b1;
        exp.data = in_window(addr) ? shadow[word_index(addr)] : 32'h0;
        exp.resp = in_window(addr) ? RESP_OKAY : RESP_DECERR;
        r_exp_q.push_back(exp);
    endtask

    task automatic expect_write(input logic [31:0] addr, input logic [3:0] id,
                                input logic [31:0] data, input logic [3:0] strb);
        axi_b_t exp;
        exp.id   = id;
        exp.resp = RESP_DECERR;
        if (in_window(addr)) begin
            shadow[word_index(addr)] = merge_bytes(shadow[word_index(addr)], data, strb);
            exp.resp = RESP_OKAY;
        end
        b_exp_q.push_back(exp);
    endtask

    task automatic drive_ar(input logic [31:0] addr, input logic [3:0] id);
        ar       = '0;
        ar.addr  = addr;
        ar.id    = id;
        ar.size  = 3'd2;        // Four bytes per beat
        ar_valid = 1'b1;
        started  = 1'b1;
    endtask

    task automatic drive_aw_w(input logic [31:0] addr, input logic [3:0] id,
                              input logic [31:0] data, input logic [3:0] strb);
        aw       = '0;
        aw.addr  = addr;
        aw.id    = id;
        aw.size  = 3'd2;
        w.data   = data;
        w.strb   = strb;
        w.last   = 1'b1;
        aw_valid = 1'b1;
        w_valid  = 1'b1;
        started  = 1'b1;
    endtask

    task automatic wait_ar_accept();
        @(negedge clk);
        while (!ar_ready) @(negedge clk);
        @(negedge clk);         // Handshake done on the edge just passed
        ar_valid = 1'b0;
    endtask

    task automatic wait_aw_accept();
        @(negedge clk);
        while (!(aw_ready && w_ready)) @(negedge clk);
        @(negedge clk);
        aw_valid = 1'b0;
        w_valid  = 1'b0;
    endtask

    task automatic collect_r(input logic bp, input int hold);
        logic done;
        done    = 1'b0;
        r_exp   = r_exp_q.pop_front();
        r_ready = 1'b0;
        repeat (hold) @(negedge clk);
        while (!done) begin
            r_ready = pick_ready(bp);
            done    = r_valid && r_ready;
            @(negedge clk);
        end
        r_ready = 1'b0;
    endtask

    task automatic collect_b(input logic bp, input int hold);
        logic done;
        done    = 1'b0;
        b_exp   = b_exp_q.pop_front();
        b_ready = 1'b0;
        repeat (hold) @(negedge clk);
        while (!done) begin
            b_ready = pick_ready(bp);
            done    = b_valid && b_ready;
            @(negedge clk);
        end
        b_ready = 1'b0;
    endtask

    task automatic read_word(input logic [31:0] addr, input logic [3:0] id,
                             input logic bp, input int hold);
        expect_read(addr, id);
        drive_ar(addr, id);
        wait_ar_accept();
        collect_r(bp, hold);
    endtask

    task automatic write_word(input logic [31:0] addr, input logic [3:0] id,
                              input logic [31:0] data, input logic [3:0] strb, input logic bp);
        expect_write(addr, id, data, strb);
        drive_aw_w(addr, id, data, strb);
        wait_aw_accept();
        collect_b(bp, 0);
    endtask

    // Read and write presented together with the read expected first
    task automatic read_and_write(input logic [31:0] raddr, input logic [3:0] rid,
                                  input logic [31:0] waddr, input logic [3:0] wid,
                                  input logic [31:0] data, input logic [3:0] strb);
        expect_read(raddr, rid);
        expect_write(waddr, wid, data, strb);
        ar_hs_mark = ar_hs_count;
        dual_test  = 1'b1;
        drive_ar(raddr, rid);
        drive_aw_w(waddr, wid, data, strb);
        wait_ar_accept();
        collect_r(1'b0, 6);
        wait_aw_accept();
        collect_b(1'b0, 0);
        dual_test = 1'b0;
    endtask

    task automatic report_test(input int num, input string name, input int err_before);
        if (errors == err_before) begin
            tests_passed++;
            $display("test %0d %s: pass", num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: fail, %0d errors", num, name, errors - err_before);
        end
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Run stopped after %0d cycles, a handshake never completed", cycle_count);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        logic [31:0] v;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
        logic [5:0]  near_idx;
        logic [31:0] oob [4];
        int          err_mark;
        ar        = '0;
        ar_valid  = 1'b0;
        aw        = '0;
        aw_valid  = 1'b0;
        w         = '0;
        w_valid   = 1'b0;
        b_ready   = 1'b0;
        r_ready   = 1'b0;
        started   = 1'b0;
        dual_test = 1'b0;
        ar_hs_mark = 0;
        @(negedge rst);
        @(negedge clk);

        err_mark = errors;
        repeat (4) @(negedge clk);
        report_test(1, "reset_idle", err_mark);

        err_mark = errors;
        for (int i = 0; i < PRELOAD; i++) begin
            v = lcg_next();
            write_word(BASE_ADDR + 32'(i * 4), v[7:4], lcg_next(), 4'hF, 1'b0);
        end
        for (int i = 0; i < 8; i++) begin
            v = lcg_next();
            read_word(BASE_ADDR + 32'({v[5:0], 2'b00}), v[11:8], 1'b0, 0);
        end
        report_test(2, "write_read", err_mark);

        err_mark = errors;
        for (int i = 0; i < 8; i++) begin
            v    = lcg_next();
            addr = BASE_ADDR + 32'({v[5:0], 2'b00});
            strb = (v[15:12] == 4'h0) ? 4'h5 : v[15:12];
            write_word(addr, v[11:8], lcg_next(), strb, 1'b0);
            read_word(addr, v[19:16], 1'b0, 0);
        end
        report_test(3, "partial_strobe", err_mark);

        err_mark = errors;
        oob[0] = BASE_ADDR + WIN_BYTES;
        oob[1] = BASE_ADDR + WIN_BYTES + 32'd68;
        oob[2] = BASE_ADDR + (WIN_BYTES << 1) + 32'd160;
        oob[3] = BASE_ADDR - WIN_BYTES + 32'd12;     // Below the window
        for (int i = 0; i < 4; i++) begin
            v        = lcg_next();
            near_idx = 6'((oob[i] - BASE_ADDR) >> 2);  // Word the address would alias
            write_word(oob[i], v[3:0], lcg_next(), 4'hF, 1'b0);
            read_word(oob[i], v[7:4], 1'b0, 0);
            read_word(BASE_ADDR + 32'({near_idx, 2'b00}), v[11:8], 1'b0, 0);
        end
        report_test(4, "out_of_window", err_mark);

        err_mark = errors;
        read_and_write(BASE_ADDR + 32'd40, 4'h3, BASE_ADDR + 32'd40, 4'hC, lcg_next(), 4'hF);
        read_word(BASE_ADDR + 32'd40, 4'h7, 1'b0, 6);
        report_test(5, "read_priority_hold", err_mark);

        err_mark = errors;
        for (int i = 0; i < N_RANDOM; i++) begin
            v    = lcg_next();
            addr = BASE_ADDR + 32'({v[5:0], 2'b00});
            if (v[30:28] == 3'd0) begin
                addr = addr + WIN_BYTES;    // Occasional miss
            end
            if (v[31]) begin
                data = lcg_next();
                strb = data[19:16];
                write_word(addr, v[11:8], data, strb, 1'b1);
            end else begin
                read_word(addr, v[11:8], 1'b1, 0);
            end
        end
        report_test(6, "random_traffic", err_mark);

        $display("tests run %0d, passed %0d, failed %0d, assertion errors %0d",
                 tests_passed + tests_failed, tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;     // Released on a falling edge
    end

endmodule

// File: axi_sram_top.sv
`timescale 1ns/1ps

module axi_sram_top
    import axi_pkg::*, mem_pkg::*;
#(
    parameter logic [AXI_ADDR_W-1:0] BASE_ADDR   = 32'h8000_0000,
    parameter int                    DEPTH_WORDS = 256
) (
    input  logic    clk,
    input  logic    rst,

    input  axi_ar_t ar,
    input  logic    ar_valid,
    output logic    ar_ready,

    input  axi_aw_t aw,
    input  logic    aw_valid,
    output logic    aw_ready,

    input  axi_w_t  w,
    input  logic    w_valid,
    output logic    w_ready,

    output axi_b_t  b,
    output logic    b_valid,
    input  logic    b_ready,

    output axi_r_t  r,
    output logic    r_valid,
    input  logic    r_ready
);

    mem_req_t  mem_req;
    mem_word_u mem_rdata;

    axi_sram_ctrl #(
        .BASE_ADDR   (BASE_ADDR),
        .DEPTH_WORDS (DEPTH_WORDS)
    ) u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .ar        (ar),
        .ar_valid  (ar_valid),
        .ar_ready  (ar_ready),
        .aw        (aw),
        .aw_valid  (aw_valid),
        .aw_ready  (aw_ready),
        .w         (w),
        .w_valid   (w_valid),
        .w_ready   (w_ready),
        .b         (b),
        .b_valid   (b_valid),
        .b_ready   (b_ready),
        .r         (r),
        .r_valid   (r_valid),
        .r_ready   (r_ready),
        .mem_req   (mem_req),
        .mem_rdata (mem_rdata)
    );

    sram_array #(
        .DEPTH_WORDS (DEPTH_WORDS)
    ) u_array (
        .clk   (clk),
        .req   (mem_req),
        .rdata (mem_rdata)
    );

endmodule

// File: axi_sram_ctrl.sv
`timescale 1ns/1ps

module axi_sram_ctrl
    import axi_pkg::*, mem_pkg::*;
#(
    parameter logic [AXI_ADDR_W-1:0] BASE_ADDR   = 32'h8000_0000,
    parameter int                    DEPTH_WORDS = 256
) (
    input  logic      clk,
    input  logic      rst,

    input  axi_ar_t   ar,
    input  logic      ar_valid,
    output logic      ar_ready,

    input  axi_aw_t   aw,
    input  logic      aw_valid,
    output logic      aw_ready,

    input  axi_w_t    w,
    input  logic      w_valid,
    output logic      w_ready,

    output axi_b_t    b,
    output logic      b_valid,
    input  logic      b_ready,

    output axi_r_t    r,
    output logic      r_valid,
    input  logic      r_ready,

    output mem_req_t  mem_req,
    input  mem_word_u mem_rdata
);

    localparam int unsigned WIN_BYTES = DEPTH_WORDS * 4;

    typedef enum logic {
        IDLE,
        BUSY
    } state_t;

    state_t                state;
    logic                  is_rd;      // Current transaction is a read
    logic                  hit;        // Address inside the window
    logic [AXI_ID_W-1:0]   id_q;
    logic [MEM_IDX_W-1:0]  idx_q;

    logic [AXI_ADDR_W-1:0] req_addr;
    logic [AXI_ADDR_W-1:0] req_off;
    logic                  req_hit;
    logic                  ar_fire;
    logic                  wr_fire;
    logic                  r_load;
    logic                  b_load;

    // Read address wins the decode when both are pending
    assign req_addr = ar_valid ? ar.addr : aw.addr;
    assign req_off  = req_addr - BASE_ADDR;
    assign req_hit  = (req_addr >= BASE_ADDR) && (req_off < WIN_BYTES);

    assign ar_fire = ar_valid && ar_ready;
    assign wr_fire = aw_valid && aw_ready && w_valid && w_ready;

    // Response is built the cycle after the address handshake
    assign r_load = (state == BUSY) && is_rd && !ar_ready && !r_valid;
    assign b_load = (state == BUSY) && !is_rd && !aw_ready && !b_valid;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= IDLE;
            is_rd    <= 1'b0;
            hit      <= 1'b0;
            ar_ready <= 1'b0;
            aw_ready <= 1'b0;
            w_ready  <= 1'b0;
            r_valid  <= 1'b0;
            b_valid  <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (ar_valid) begin
                        state    <= BUSY;
                        is_rd    <= 1'b1;
                        hit      <= req_hit;
                        ar_ready <= 1'b1;
                    end else if (aw_valid && w_valid) begin
                        state    <= BUSY;
                        is_rd    <= 1'b0;
                        hit      <= req_hit;
                        aw_ready <= 1'b1;
                        w_ready  <= 1'b1;
                    end
                end
                BUSY: begin
                    if (is_rd) begin
                        if (ar_ready) begin
                            if (ar_valid) begin
                                ar_ready <= 1'b0;
                            end
                        end else if (!r_valid) begin
                            r_valid <= 1'b1;
                        end else if (r_ready) begin
                            r_valid <= 1'b0;
                            state   <= IDLE;
                        end
                    end else begin
                        if (aw_ready) begin
                            if (wr_fire) begin
                                aw_ready <= 1'b0;
                                w_ready  <= 1'b0;
                            end
                        end else if (!b_valid) begin
                            b_valid <= 1'b1;
                        end else if (b_ready) begin
                            b_valid <= 1'b0;
                            state   <= IDLE;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE) begin
            id_q  <= ar_valid ? ar.id : aw.id;
            idx_q <= MEM_IDX_W'(req_off >> 2);  // Byte offset to word index
        end
        if (r_load) begin
            r.data <= hit ? mem_rdata.word : '0;
            r.id   <= id_q;
            r.resp <= hit ? RESP_OKAY : RESP_DECERR;
            r.last <= 1'b1;                 // Always a single beat
        end
        if (b_load) begin
            b.id   <= id_q;
            b.resp <= hit ? RESP_OKAY : RESP_DECERR;
        end
    end

    // Storage access fires on the address handshake edge
    always_comb begin
        mem_req            = '0;
        mem_req.idx        = idx_q;
        mem_req.wdata.word = w.data;
        mem_req.strb       = w.strb;
        if (hit) begin
            if (is_rd) begin
                mem_req.en = ar_fire;
            end else begin
                mem_req.en = wr_fire;
                mem_req.we = wr_fire;
            end
        end
    end

    a_one_response: assert property (
        @(posedge clk) disable iff (rst) !(r_valid && b_valid)
    ) else $error("r_valid and b_valid high together");

    a_r_stable: assert property (
        @(posedge clk) disable iff (rst)
        (r_valid && !r_ready) |=> (r_valid && $stable(r))
    ) else $error("R channel changed before its handshake");

    a_single_beat: assert property (
        @(posedge clk) disable iff (rst)
        !((ar_fire && ar.len != '0) || (wr_fire && aw.len != '0))
    ) else $error("Burst request accepted, only single beats are served");

endmodule

// File: sram_array.sv
`timescale 1ns/1ps

module sram_array
    import mem_pkg::*;
#(
    parameter int DEPTH_WORDS = 256
) (
    input  logic      clk,
    input  mem_req_t  req,
    output mem_word_u rdata
);

    localparam int IDX_W = (DEPTH_WORDS > 1) ? $clog2(DEPTH_WORDS) : 1;

    mem_word_u        mem [DEPTH_WORDS];
    logic [IDX_W-1:0] idx;

    assign idx = req.idx[IDX_W-1:0];

    // Byte lanes written only where strobed
    always_ff @(posedge clk) begin
        if (req.en && req.we) begin
            for (int i = 0; i < MEM_BYTE_N; i++) begin
                if (req.strb[i]) begin
                    mem[idx].bytes[i] <= req.wdata.bytes[i];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req.en && !req.we) begin
            rdata.word <= mem[idx].word;    // One cycle latency
        end
    end

    // Controller decode must keep every access inside the array
    a_idx_in_range: assert property (
        @(posedge clk) req.en |-> (req.idx < MEM_IDX_W'(DEPTH_WORDS))
    ) else $error("sram_array index 0x%08h out of range", req.idx);

endmodule

// File: mem_pkg.sv
package mem_pkg;

    localparam int MEM_WORD_W = 32;
    localparam int MEM_BYTE_N = MEM_WORD_W / 8;
    localparam int MEM_IDX_W  = 32;

    // One storage word seen whole or byte by byte
    typedef union packed {
        logic [MEM_WORD_W-1:0]       word;
        logic [MEM_BYTE_N-1:0][7:0]  bytes;
    } mem_word_u;

    typedef struct packed {
        logic                  en;
        logic                  we;
        logic [MEM_IDX_W-1:0]  idx;    // Word index with upper bits unused
        mem_word_u             wdata;
        logic [MEM_BYTE_N-1:0] strb;
    } mem_req_t;

endpackage

// File: axi_pkg.sv
package axi_pkg;

    localparam int AXI_ADDR_W  = 32;
    localparam int AXI_DATA_W  = 32;
    localparam int AXI_ID_W    = 4;
    localparam int AXI_STRB_W  = AXI_DATA_W / 8;
    localparam int AXI_LEN_W   = 8;
    localparam int AXI_SIZE_W  = 3;
    localparam int AXI_BURST_W = 2;

    typedef logic [1:0] axi_resp_t;

    localparam axi_resp_t RESP_OKAY   = 2'b00;
    localparam axi_resp_t RESP_DECERR = 2'b11;  // No slave at this address

    typedef struct packed {
        logic [AXI_ADDR_W-1:0]  addr;
        logic [AXI_ID_W-1:0]    id;
        logic [AXI_LEN_W-1:0]   len;    // Beats minus one
        logic [AXI_SIZE_W-1:0]  size;
        logic [AXI_BURST_W-1:0] burst;
    } axi_ar_t;

    // Write address channel carries the same fields as read address
    typedef axi_ar_t axi_aw_t;

    typedef struct packed {
        logic [AXI_DATA_W-1:0] data;
        logic [AXI_STRB_W-1:0] strb;
        logic                  last;
    } axi_w_t;

    typedef struct packed {
        logic [AXI_ID_W-1:0] id;
        axi_resp_t           resp;
    } axi_b_t;

    typedef struct packed {
        logic [AXI_DATA_W-1:0] data;
        logic [AXI_ID_W-1:0]   id;
        axi_resp_t             resp;
        logic                  last;
    } axi_r_t;

endpackage
